//--- logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_W   32
`define REG_N    32
`define LINK_REG 5'd31

// ****************************************
// primary opcodes.
`define OPC_REGIMM 6'b000001
`define OPC_BEQ    6'b000100
`define OPC_BNE    6'b000101
`define OPC_BLEZ   6'b000110
`define OPC_BGTZ   6'b000111
`define OPC_ADDI   6'b001000
`define OPC_ADDIU  6'b001001
`define OPC_SLTI   6'b001010
`define OPC_SLTIU  6'b001011
`define OPC_ANDI   6'b001100
`define OPC_ORI    6'b001101
`define OPC_XORI   6'b001110
`define OPC_LUI    6'b001111
`define OPC_LW     6'b100011
`define OPC_SW     6'b101011

// ****************************************
// rt field under REGIMM.
`define OPC_RT_BLTZ   5'b00000
`define OPC_RT_BGEZ   5'b00001
`define OPC_RT_TEQI   5'b01100
`define OPC_RT_BLTZAL 5'b10000
`define OPC_RT_BGEZAL 5'b10001

`endif

//--- logic/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

	typedef logic                Bit_t;
	typedef logic [`WORD_W-1:0]  Word_t;
	typedef logic [31:0]         Inst_t;
	typedef logic [4:0]          RegAddr_t;

	typedef enum logic [4:0]
	{
		OP_INVALID,
		OP_ANDI,
		OP_ORI,
		OP_XORI,
		OP_LUI,
		OP_ADDI,
		OP_ADDIU,
		OP_SLTI,
		OP_SLTIU,
		OP_BEQ,
		OP_BNE,
		OP_BLEZ,
		OP_BGTZ,
		OP_BLTZ,
		OP_BGEZ,
		OP_BLTZAL,
		OP_BGEZAL,
		OP_TEQI,
		OP_LW,
		OP_SW
	} Oper_t;

	// instruction as it enters the core.
	typedef struct packed
	{
		Word_t pc;
		Inst_t inst;
	} issue_t;

	typedef struct packed
	{
		Oper_t       op;
		Word_t       pc;
		logic [15:0] imm;
		Bit_t        unsigned_imm;  // zero extend.
		Word_t       a;             // rs value.
		Word_t       b;             // rt value.
		RegAddr_t    waddr;
		Bit_t        we;
	} dec_pkt_t;

	typedef enum logic [1:0]
	{
		EXC_NONE,
		EXC_OVF,
		EXC_TRAP,
		EXC_RI
	} exc_t;

	// retire packet.
	typedef struct packed
	{
		Oper_t    op;
		Word_t    pc;
		Bit_t     we;
		RegAddr_t waddr;
		Word_t    wdata;
		Bit_t     taken;
		Word_t    target;
		exc_t     exc;
	} res_t;

endpackage

//--- logic/id_type_i.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module id_type_i
	import cpu_pkg::*;
(
	input  logic [5:0] opcode,
	input  Inst_t      inst,
	output Oper_t      op,
	output RegAddr_t   reg_raddr1,
	output RegAddr_t   reg_raddr2,
	output RegAddr_t   reg_waddr,
	output Bit_t       reg_we,
	output Bit_t       unsigned_imm
);

	RegAddr_t rs;
	RegAddr_t rt;

	assign rs = inst[25:21];
	assign rt = inst[20:16];

	// logic ops take a zero extended immediate.
	assign unsigned_imm = (opcode == `OPC_ANDI) ||
		(opcode == `OPC_ORI) ||
		(opcode == `OPC_XORI);

	// ****************************************
	// operation select.
	always_comb
	begin
		op = OP_INVALID;
		case (opcode)
			`OPC_REGIMM:
			begin
				case (rt)
					`OPC_RT_BLTZ:   op = OP_BLTZ;
					`OPC_RT_BGEZ:   op = OP_BGEZ;
					`OPC_RT_BLTZAL: op = OP_BLTZAL;
					`OPC_RT_BGEZAL: op = OP_BGEZAL;
					`OPC_RT_TEQI:   op = OP_TEQI;
					default:        op = OP_INVALID;
				endcase
			end
			`OPC_ANDI:  op = OP_ANDI;
			`OPC_ORI:   op = OP_ORI;
			`OPC_XORI:  op = OP_XORI;
			`OPC_LUI:   op = OP_LUI;
			`OPC_ADDI:  op = OP_ADDI;
			`OPC_ADDIU: op = OP_ADDIU;
			`OPC_SLTI:  op = OP_SLTI;
			`OPC_SLTIU: op = OP_SLTIU;
			`OPC_BEQ:   op = OP_BEQ;
			`OPC_BNE:   op = OP_BNE;
			`OPC_BLEZ:  op = OP_BLEZ;
			`OPC_BGTZ:  op = OP_BGTZ;
			`OPC_LW:    op = OP_LW;
			`OPC_SW:    op = OP_SW;
			default:    op = OP_INVALID;
		endcase
	end

	// ****************************************
	// register usage per operation.
	always_comb
	begin
		reg_raddr1 = rs;
		reg_raddr2 = 5'd0;
		reg_waddr  = rt;
		reg_we     = 1'b0;
		case (op)
			OP_ANDI, OP_ORI, OP_XORI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
				reg_we = 1'b1;
			OP_LUI:
			begin
				reg_raddr1 = 5'd0;  // no source.
				reg_we     = 1'b1;
			end
			OP_BEQ, OP_BNE:
				reg_raddr2 = rt;
			OP_BLTZAL, OP_BGEZAL:
			begin
				reg_waddr = `LINK_REG;
				reg_we    = 1'b1;
			end
			OP_LW:
			begin
				reg_raddr2 = rt;
				reg_we     = 1'b1;
			end
			OP_SW:
				reg_raddr2 = rt;
			default:
				reg_we = 1'b0;
		endcase
	end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [$clog2(`REG_N)-1:0] raddr1,
	input  logic [$clog2(`REG_N)-1:0] raddr2,
	input  logic                       wr_en,
	input  logic [$clog2(`REG_N)-1:0] wr_addr,
	input  logic [`WORD_W-1:0]         wr_data,
	output logic [`WORD_W-1:0]         rdata1,
	output logic [`WORD_W-1:0]         rdata2
);

	logic [`WORD_W-1:0] regs [`REG_N];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `REG_N; i++)
				regs[i] <= '0;
		end
		else if (wr_en && wr_addr != '0)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	// r0 hardwired.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_stage
	import cpu_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  issue_t   in_data,
	output logic     in_ready,
	output logic     dec_valid,
	output dec_pkt_t dec_data,
	input  logic     dec_ready,
	output RegAddr_t raddr1,
	output RegAddr_t raddr2,
	input  Word_t    rdata1,
	input  Word_t    rdata2,
	input  logic     retire_we,
	input  RegAddr_t retire_waddr
);

	Oper_t              op;
	RegAddr_t           waddr;
	Bit_t               we;
	Bit_t               unsigned_imm;
	logic [`REG_N-1:0] pending;  // one bit per register.
	logic               hazard;
	logic               fire;

	id_type_i u_dec
	(
		.opcode       (in_data.inst[31:26]),
		.inst         (in_data.inst),
		.op           (op),
		.reg_raddr1   (raddr1),
		.reg_raddr2   (raddr2),
		.reg_waddr    (waddr),
		.reg_we       (we),
		.unsigned_imm (unsigned_imm)
	);

	// a second writer to a pending register waits as well.
	assign hazard = (raddr1 != '0 && pending[raddr1]) ||
		(raddr2 != '0 && pending[raddr2]) ||
		(we && waddr != '0 && pending[waddr]);

	assign dec_valid = in_valid && !hazard;
	assign in_ready  = dec_ready && !hazard;
	assign fire      = dec_valid && dec_ready;

	always_comb
	begin
		dec_data.op           = op;
		dec_data.pc           = in_data.pc;
		dec_data.imm          = in_data.inst[15:0];
		dec_data.unsigned_imm = unsigned_imm;
		dec_data.a            = rdata1;
		dec_data.b            = rdata2;
		dec_data.waddr        = waddr;
		dec_data.we           = we;
	end

	// ****************************************
	// scoreboard.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pending <= '0;
		end
		else
		begin
			if (retire_we)
				pending[retire_waddr] <= 1'b0;
			if (fire && we && waddr != '0)
				pending[waddr] <= 1'b1;  // r0 never tracked.
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		retire_we && retire_waddr != '0 |-> pending[retire_waddr]);

endmodule

//--- logic/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg
#(
	parameter type payload_t = logic
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     s_valid,
	input  payload_t s_data,
	output logic     s_ready,
	output logic     m_valid,
	output payload_t m_data,
	input  logic     m_ready
);

	// empty, or draining this cycle.
	assign s_ready = !m_valid || m_ready;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			m_valid <= 1'b0;
		else if (s_ready)
			m_valid <= s_valid;
	end

	always_ff @(posedge clk)
	begin
		if (s_valid && s_ready)
			m_data <= s_data;
	end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
	import cpu_pkg::*;
(
	input  dec_pkt_t dec_data,
	output res_t     exe_data
);

	Word_t imm_ext;
	Word_t sum;
	Word_t pc_plus4;
	Word_t br_off;
	logic  ovf;
	logic  a_neg;
	logic  a_zero;

	assign imm_ext = dec_data.unsigned_imm ? {16'h0000, dec_data.imm} :
		{{16{dec_data.imm[15]}}, dec_data.imm};

	assign sum = dec_data.a + imm_ext;

	// same input signs, different result sign.
	assign ovf = (dec_data.a[31] == imm_ext[31]) && (sum[31] != dec_data.a[31]);

	assign pc_plus4 = dec_data.pc + 32'd4;
	assign br_off   = {{14{dec_data.imm[15]}}, dec_data.imm, 2'b00};
	assign a_neg    = dec_data.a[31];
	assign a_zero   = (dec_data.a == '0);

	// ****************************************
	// result select.
	always_comb
	begin
		exe_data.op     = dec_data.op;
		exe_data.pc     = dec_data.pc;
		exe_data.we     = dec_data.we;  // masked at retire on exception.
		exe_data.waddr  = dec_data.waddr;
		exe_data.wdata  = '0;
		exe_data.taken  = 1'b0;
		exe_data.target = pc_plus4 + br_off;
		exe_data.exc    = EXC_NONE;
		case (dec_data.op)
			OP_ANDI:  exe_data.wdata = dec_data.a & imm_ext;
			OP_ORI:   exe_data.wdata = dec_data.a | imm_ext;
			OP_XORI:  exe_data.wdata = dec_data.a ^ imm_ext;
			OP_LUI:   exe_data.wdata = {dec_data.imm, 16'h0000};
			OP_ADDI:
			begin
				exe_data.wdata = sum;
				if (ovf)
					exe_data.exc = EXC_OVF;
			end
			OP_ADDIU: exe_data.wdata = sum;
			OP_SLTI:
				exe_data.wdata = {31'd0, $signed(dec_data.a) < $signed(imm_ext)};
			OP_SLTIU: exe_data.wdata = {31'd0, dec_data.a < imm_ext};
			OP_BEQ:   exe_data.taken = (dec_data.a == dec_data.b);
			OP_BNE:   exe_data.taken = (dec_data.a != dec_data.b);
			OP_BLEZ:  exe_data.taken = a_neg || a_zero;
			OP_BGTZ:  exe_data.taken = !a_neg && !a_zero;
			OP_BLTZ:  exe_data.taken = a_neg;
			OP_BGEZ:  exe_data.taken = !a_neg;
			OP_BLTZAL:
			begin
				exe_data.taken = a_neg;
				exe_data.wdata = dec_data.pc + 32'd8;  // link either way.
			end
			OP_BGEZAL:
			begin
				exe_data.taken = !a_neg;
				exe_data.wdata = dec_data.pc + 32'd8;
			end
			OP_TEQI:
			begin
				if (dec_data.a == imm_ext)
					exe_data.exc = EXC_TRAP;
			end
			default:  exe_data.exc = EXC_RI;  // lw, sw, undefined.
		endcase
	end

endmodule

//--- logic/result_stage.sv
`timescale 1ns/1ps

module result_stage
	import cpu_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     res_valid,
	input  res_t     res_data,
	output logic     res_ready,
	output logic     out_valid,
	output res_t     out_data,
	input  logic     out_ready,
	output logic     wr_en,
	output RegAddr_t wr_addr,
	output Word_t    wr_data,
	output logic     retire_we,
	output RegAddr_t retire_waddr
);

	logic fire;

	assign out_valid = res_valid;
	assign res_ready = out_ready;
	assign fire      = res_valid && out_ready;

	always_comb
	begin
		out_data    = res_data;
		out_data.we = res_data.we && (res_data.exc == EXC_NONE);
	end

	// commit on the output handshake.
	assign wr_en   = fire && out_data.we;
	assign wr_addr = res_data.waddr;
	assign wr_data = res_data.wdata;

	// release follows the decoded write, excepted or not.
	assign retire_we    = fire && res_data.we;
	assign retire_waddr = res_data.waddr;

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid);

endmodule

//--- logic/ie_core.sv
`timescale 1ns/1ps

module ie_core
	import cpu_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid,
	input  issue_t in_data,
	output logic   in_ready,
	output logic   out_valid,
	output res_t   out_data,
	input  logic   out_ready
);

	logic     dec_valid;
	logic     dec_ready;
	dec_pkt_t dec_data;
	logic     dq_valid;
	logic     dq_ready;
	dec_pkt_t dq_data;
	res_t     exe_data;
	logic     exe_ready;
	logic     eq_valid;
	logic     eq_ready;
	res_t     eq_data;
	RegAddr_t raddr1;
	RegAddr_t raddr2;
	Word_t    rdata1;
	Word_t    rdata2;
	logic     wr_en;
	RegAddr_t wr_addr;
	Word_t    wr_data;
	logic     retire_we;
	RegAddr_t retire_waddr;

	// ****************************************
	// pipeline.
	decode_stage u_decode
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_data      (in_data),
		.in_ready     (in_ready),
		.dec_valid    (dec_valid),
		.dec_data     (dec_data),
		.dec_ready    (dec_ready),
		.raddr1       (raddr1),
		.raddr2       (raddr2),
		.rdata1       (rdata1),
		.rdata2       (rdata2),
		.retire_we    (retire_we),
		.retire_waddr (retire_waddr)
	);

	pipe_reg #(.payload_t(dec_pkt_t)) dec_q
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.s_valid (dec_valid),
		.s_data  (dec_data),
		.s_ready (dec_ready),
		.m_valid (dq_valid),
		.m_data  (dq_data),
		.m_ready (dq_ready)
	);

	execute_stage u_execute
	(
		.dec_data (dq_data),
		.exe_data (exe_data)
	);

	// execute is combinational, so the handshake passes straight across.
	assign dq_ready = exe_ready;

	pipe_reg #(.payload_t(res_t)) exe_q
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.s_valid (dq_valid),
		.s_data  (exe_data),
		.s_ready (exe_ready),
		.m_valid (eq_valid),
		.m_data  (eq_data),
		.m_ready (eq_ready)
	);

	result_stage u_result
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.res_valid    (eq_valid),
		.res_data     (eq_data),
		.res_ready    (eq_ready),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.out_ready    (out_ready),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.retire_we    (retire_we),
		.retire_waddr (retire_waddr)
	);

	reg_file u_regs
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.raddr1  (raddr1),
		.raddr2  (raddr2),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rdata1  (rdata1),
		.rdata2  (rdata2)
	);

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
	parameter real period = 8.0
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(period / 2.0) clk = ~clk;
	end

endmodule

//--- sim/ie_core_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module ie_core_tb
	import cpu_pkg::*;
;

	localparam int n_t1 = 34;
	localparam int n_t2 = 32;
	localparam int n_t3 = 39;
	localparam int n_t4 = 27;
	localparam int n_t5 = 16;
	localparam int n_t6 = 40;
	localparam int n_total = n_t1 + n_t2 + n_t3 + n_t4 + n_t5 + n_t6;

	logic   clk;
	logic   rst_n;
	logic   in_valid;
	issue_t in_data;
	logic   in_ready;
	logic   out_valid;
	res_t   out_data;
	logic   out_ready;
	logic   hs;

	int          seed = 32'ha939_37d6;
	int          errors = 0;
	int          retired = 0;
	logic        stall_en = 1'b0;
	Word_t       pc = 32'h0000_1000;
	issue_t      pend_q[$];
	Word_t       mregs [`REG_N];
	res_t        exp;
	logic        exp_br;
	logic        have_exp;

	tb_clock #(.period(8.0)) u_clk (.clk(clk));

	ie_core uut
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready)
	);

	assign hs = out_valid && out_ready;

	task automatic report_mismatch(input string name, input logic [31:0] e,
		input logic [31:0] a);
		errors++;
		$display("Fail %s: expected %08h, got %08h", name, e, a);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	function automatic Inst_t itype(input logic [5:0] opc, input int rs, input int rt,
		input logic [15:0] imm);
		return {opc, rs[4:0], rt[4:0], imm};
	endfunction

	// ****************************************
	// reference model.
	function automatic res_t predict(input issue_t p, output logic br);
		res_t        r;
		logic [5:0]  opc;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
		Word_t       a;
		Word_t       b;
		Word_t       sx;
		Word_t       zx;
		Word_t       s;
		longint      exact;  // sum without wrap.
		opc = p.inst[31:26];
		rs  = p.inst[25:21];
		rt  = p.inst[20:16];
		imm = p.inst[15:0];
		a   = mregs[rs];
		b   = mregs[rt];
		sx  = {{16{imm[15]}}, imm};
		zx  = {16'h0000, imm};
		s   = a + sx;
		exact = longint'($signed(a)) + longint'($signed(sx));
		r        = '0;
		r.pc     = p.pc;
		r.waddr  = rt;
		r.target = p.pc + 32'd4 + (sx << 2);
		r.exc    = EXC_NONE;
		r.op     = OP_INVALID;
		br       = 1'b0;
		case (opc)
			`OPC_ANDI:
			begin
				r.op    = OP_ANDI;
				r.we    = 1'b1;
				r.wdata = a & zx;
			end
			`OPC_ORI:
			begin
				r.op    = OP_ORI;
				r.we    = 1'b1;
				r.wdata = a | zx;
			end
			`OPC_XORI:
			begin
				r.op    = OP_XORI;
				r.we    = 1'b1;
				r.wdata = a ^ zx;
			end
			`OPC_LUI:
			begin
				r.op    = OP_LUI;
				r.we    = 1'b1;
				r.wdata = {imm, 16'h0000};
			end
			`OPC_ADDIU:
			begin
				r.op    = OP_ADDIU;
				r.we    = 1'b1;
				r.wdata = s;
			end
			`OPC_SLTI:
			begin
				r.op = OP_SLTI;
				r.we = 1'b1;
				r.wdata = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
			end
			`OPC_SLTIU:
			begin
				r.op    = OP_SLTIU;
				r.we    = 1'b1;
				r.wdata = (a < sx) ? 32'd1 : 32'd0;
			end
			`OPC_ADDI:
			begin
				r.op = OP_ADDI;
				r.wdata = s;
				if (exact != longint'($signed(s)))
					r.exc = EXC_OVF;
				else
					r.we = 1'b1;
			end
			`OPC_BEQ:
			begin
				r.op    = OP_BEQ;
				br      = 1'b1;
				r.taken = (a == b);
			end
			`OPC_BNE:
			begin
				r.op    = OP_BNE;
				br      = 1'b1;
				r.taken = (a != b);
			end
			`OPC_BLEZ:
			begin
				r.op    = OP_BLEZ;
				br      = 1'b1;
				r.taken = ($signed(a) <= 0);
			end
			`OPC_BGTZ:
			begin
				r.op    = OP_BGTZ;
				br      = 1'b1;
				r.taken = ($signed(a) > 0);
			end
			`OPC_LW:
			begin
				r.op  = OP_LW;
				r.exc = EXC_RI;
			end
			`OPC_SW:
			begin
				r.op  = OP_SW;
				r.exc = EXC_RI;
			end
			`OPC_REGIMM:
			begin
				br = 1'b1;
				case (rt)
					`OPC_RT_BLTZ:
					begin
						r.op    = OP_BLTZ;
						r.taken = ($signed(a) < 0);
					end
					`OPC_RT_BGEZ:
					begin
						r.op    = OP_BGEZ;
						r.taken = ($signed(a) >= 0);
					end
					`OPC_RT_BLTZAL, `OPC_RT_BGEZAL:
					begin
						r.op    = (rt == `OPC_RT_BLTZAL) ? OP_BLTZAL : OP_BGEZAL;
						r.taken = (rt == `OPC_RT_BLTZAL) ? ($signed(a) < 0) : ($signed(a) >= 0);
						r.we    = 1'b1;
						r.waddr = `LINK_REG;
						r.wdata = p.pc + 32'd8;
					end
					`OPC_RT_TEQI:
					begin
						r.op = OP_TEQI;
						br = 1'b0;
						if (a == sx)
							r.exc = EXC_TRAP;
					end
					default:
					begin
						br    = 1'b0;
						r.exc = EXC_RI;
					end
				endcase
			end
			default:    r.exc = EXC_RI;
		endcase
		return r;
	endfunction

	task automatic refresh_exp();
		logic br;
		res_t r;
		br = 1'b0;
		r  = '0;
		if (pend_q.size() != 0)
			r = predict(pend_q[0], br);
		have_exp <= (pend_q.size() != 0);
		exp      <= r;
		exp_br   <= br;
	endtask

	// model commit at each output handshake.
	always @(posedge clk)
	begin
		if (rst_n && hs && have_exp)
		begin
			if (exp.we && exp.waddr != '0)
				mregs[exp.waddr] = exp.wdata;
			void'(pend_q.pop_front());
			retired++;
			refresh_exp();
		end
	end

	// ****************************************
	// checks.
	assert property (@(posedge clk) disable iff (!rst_n) hs |-> have_exp)
		else report_error("Output handshake with no instruction outstanding");
	assert property (@(posedge clk) disable iff (!rst_n) hs |-> out_data.op == exp.op)
		else report_mismatch("op", 32'($sampled(exp.op)), 32'($sampled(out_data.op)));
	assert property (@(posedge clk) disable iff (!rst_n) hs |-> out_data.pc == exp.pc)
		else report_mismatch("pc", $sampled(exp.pc), $sampled(out_data.pc));
	assert property (@(posedge clk) disable iff (!rst_n) hs |-> out_data.exc == exp.exc)
		else report_mismatch("exc", 32'($sampled(exp.exc)), 32'($sampled(out_data.exc)));
	assert property (@(posedge clk) disable iff (!rst_n) hs |-> out_data.we == exp.we)
		else report_mismatch("we", 32'($sampled(exp.we)), 32'($sampled(out_data.we)));
	assert property (@(posedge clk) disable iff (!rst_n)
		hs && exp.we |-> out_data.waddr == exp.waddr)
		else report_mismatch("waddr", 32'($sampled(exp.waddr)), 32'($sampled(out_data.waddr)));
	assert property (@(posedge clk) disable iff (!rst_n)
		hs && exp.we |-> out_data.wdata == exp.wdata)
		else report_mismatch("wdata", $sampled(exp.wdata), $sampled(out_data.wdata));
	assert property (@(posedge clk) disable iff (!rst_n) hs |-> out_data.taken == exp.taken)
		else report_mismatch("taken", 32'($sampled(exp.taken)), 32'($sampled(out_data.taken)));
	assert property (@(posedge clk) disable iff (!rst_n)
		hs && exp_br |-> out_data.target == exp.target)
		else report_mismatch("target", $sampled(exp.target), $sampled(out_data.target));
	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else report_error("Output changed while stalled");

	// random low periods on out_ready.
	always @(posedge clk)
	begin
		#1;
		out_ready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
	end

	task automatic issue(input Inst_t inst);
		logic acc;
		in_valid = 1'b1;
		in_data  = '{pc: pc, inst: inst};
		acc = 1'b0;
		while (!acc)
		begin
			@(negedge clk);
			acc = in_ready;
			@(posedge clk);
			#1;
		end
		pend_q.push_back(in_data);
		refresh_exp();
		pc += 32'd4;
		in_valid = 1'b0;
	endtask

	task automatic drain();
		while (pend_q.size() != 0)
			@(posedge clk);
		#1;
	endtask

	function automatic int rnd_reg();
		return 1 + int'($unsigned($random(seed)) % 7);
	endfunction

	task automatic end_test(input string name, input int err_before);
		drain();
		$display("%s: %0d errors", name, errors - err_before);
	endtask

	// ****************************************
	// stimulus.
	initial
	begin
		int          e0;
		logic [15:0] imm;
		logic [5:0]  ops [4];
		logic [5:0]  brs [6];
		logic [4:0]  rts [2];
		int          srcs [3];
		for (int i = 0; i < `REG_N; i++)
			mregs[i] = '0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b1;
		refresh_exp();
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;

		e0 = errors;
		#1;
		assert (!out_valid && in_ready)
			else report_error("Handshake outputs wrong after reset");
		for (int r = 0; r < 32; r++)
			issue(itype(`OPC_ORI, r, r, 16'h0000));
		issue(itype(`OPC_ORI, 0, 0, 16'h1234));
		issue(itype(`OPC_ORI, 0, 1, 16'h0000));
		end_test("reset state", e0);

		e0 = errors;
		ops = '{`OPC_ANDI, `OPC_ORI, `OPC_XORI, `OPC_LUI};
		for (int i = 0; i < 8; i++)
			for (int k = 0; k < 4; k++)
			begin
				imm = 16'($random(seed));
				issue(itype(ops[(k + 3) % 4], rnd_reg(), rnd_reg(), imm));
			end
		end_test("logic and lui", e0);

		e0 = errors;
		ops = '{`OPC_ADDI, `OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU};
		for (int i = 0; i < 8; i++)
			for (int k = 0; k < 4; k++)
			begin
				imm = 16'($random(seed));
				issue(itype(ops[k], rnd_reg(), rnd_reg(), imm));
			end
		issue(itype(`OPC_LUI, 0, 9, 16'h7fff));
		issue(itype(`OPC_ORI, 9, 9, 16'hffff));
		issue(itype(`OPC_LUI, 0, 11, 16'h8000));
		issue(itype(`OPC_ORI, 0, 10, 16'h0055));
		issue(itype(`OPC_ADDI, 9, 10, 16'h0001));   // positive overflow.
		issue(itype(`OPC_ADDI, 11, 10, 16'hffff));  // negative overflow.
		issue(itype(`OPC_ORI, 10, 18, 16'h0000));
		end_test("arithmetic and compare", e0);

		e0 = errors;
		issue(itype(`OPC_ORI, 0, 12, 16'h1234));
		issue(itype(`OPC_LUI, 0, 13, 16'h8001));
		srcs = '{0, 12, 13};
		brs = '{`OPC_BEQ, `OPC_BNE, `OPC_BLEZ, `OPC_BGTZ, `OPC_REGIMM, `OPC_REGIMM};
		rts = '{`OPC_RT_BLTZ, `OPC_RT_BGEZ};
		for (int s = 0; s < 3; s++)
		begin
			for (int k = 0; k < 4; k++)
				issue(itype(brs[k], srcs[s], 12, 16'($random(seed))));
			for (int k = 0; k < 2; k++)
				issue(itype(`OPC_REGIMM, srcs[s], int'(rts[k]), 16'($random(seed))));
			issue(itype(`OPC_REGIMM, srcs[s], int'(`OPC_RT_BLTZAL), 16'hfff0));
			issue(itype(`OPC_REGIMM, srcs[s], int'(`OPC_RT_BGEZAL), 16'h0010));
		end
		issue(itype(`OPC_ORI, 31, 14, 16'h0000));
		end_test("branches", e0);

		e0 = errors;
		for (int i = 0; i < 4; i++)
		begin
			imm = 16'($random(seed));
			issue(itype(`OPC_ADDIU, 0, 15, imm));
			issue(itype(`OPC_REGIMM, 15, int'(`OPC_RT_TEQI), imm));
			issue(itype(`OPC_REGIMM, 15, int'(`OPC_RT_TEQI), imm + 16'd1));
		end
		issue(itype(`OPC_LW, 1, 2, 16'h0004));
		issue(itype(`OPC_SW, 1, 2, 16'h0008));
		issue(itype(6'b111111, 1, 3, 16'h0000));
		issue(itype(`OPC_REGIMM, 1, 2, 16'h0000));  // undefined rt code.
		end_test("exceptions", e0);

		e0 = errors;
		stall_en = 1'b1;
		ops = '{`OPC_ADDIU, `OPC_XORI, `OPC_ORI, `OPC_SLTIU};
		for (int i = 0; i < n_t6; i++)
		begin
			imm = 16'($random(seed));
			issue(itype(ops[$unsigned($random(seed)) % 4], 16 + (i % 2), 17 - (i % 2), imm));
		end
		end_test("dependencies and back-pressure", e0);
		stall_en = 1'b0;

		$display("%0d instructions retired, %0d errors", retired, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog.
	initial
	begin
		#((16 + 200 * n_total) * 8);
		$display("Watchdog expired with %0d instructions outstanding", pend_q.size());
		$display("Test failures found");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+logic
logic/cpu_pkg.sv
logic/id_type_i.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/pipe_reg.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/ie_core.sv
sim/tb_clock.sv
sim/ie_core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module ie_core_tb -f vlog.f -o Vie_core_tb
	./obj_dir/Vie_core_tb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
